// ==== design/io_params.svh ====
/*
 * Sizing constants for the uncached I/O path
 * Included by the package and by every RTL file that sizes arrays or loops
 */
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// Hardware threads per core
`define THREADS_PER_CORE 4

// Cores sharing the I/O bus
`define NUM_CORES 2

// Memory-mapped registers, addressed by word index
`define IO_REG_COUNT 16

// Register and data word width
`define IO_DATA_WIDTH 32

`endif

// ==== design/io_pkg.sv ====
/*
 * Shared types for the uncached I/O path
 * Referenced with scoped names from the RTL and the testbench
 */
`include "io_params.svh"

package io_pkg;

	// Data and address word
	typedef logic [`IO_DATA_WIDTH - 1:0] scalar_t;

	// Thread number within a core, and one bit per thread
	typedef logic [$clog2(`THREADS_PER_CORE) - 1:0] thread_idx_t;
	typedef logic [`THREADS_PER_CORE - 1:0] thread_bitmap_t;

	// Core number on the shared bus
	typedef logic [$clog2(`NUM_CORES) - 1:0] core_id_t;

	typedef enum logic {
		IO_READ,
		IO_WRITE
	} io_op_t;

	// Per-thread state in the issue block
	typedef enum logic [1:0] {
		TS_IDLE,
		TS_READY,
		TS_SLEEP,
		TS_FINISH
	} thread_state_t;

	// Command from outside into a core
	typedef struct packed {
		logic valid;
		thread_idx_t thread_idx;
		io_op_t op;
		scalar_t address;
		scalar_t value;
	} io_cmd_t;

	// Completion out of a core
	typedef struct packed {
		logic valid;
		thread_idx_t thread_idx;
		scalar_t value;
	} io_done_t;

	// Queue to bus controller
	typedef struct packed {
		logic valid;
		logic is_store;
		thread_idx_t thread_idx;
		scalar_t address;
		scalar_t value;
	} ioreq_packet_t;

	// Bus controller to all cores
	typedef struct packed {
		logic valid;
		core_id_t core;
		thread_idx_t thread_idx;
		scalar_t read_value;
	} iorsp_packet_t;

endpackage

// ==== design/rr_arbiter.sv ====
/*
 * Round-robin arbiter with a one-hot grant
 * Priority starts at the entry after the last grant when update_lru is set
 */
`timescale 1ns/1ps

module rr_arbiter
	#(parameter NUM_ENTRIES = 4)
	(input logic clk,
	input logic reset,
	input logic [NUM_ENTRIES - 1:0] request,
	input logic update_lru,
	output logic [NUM_ENTRIES - 1:0] grant_oh);

	localparam IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

	// Entry that currently has highest priority
	logic [IDX_W - 1:0] priority_idx;
	logic [IDX_W - 1:0] grant_idx;

	// Scan from lowest priority up, so the last hit wins
	always_comb
	begin
		int slot;
		grant_oh = '0;
		grant_idx = '0;
		for (int i = NUM_ENTRIES - 1; i >= 0; i--)
		begin
			slot = (int'(priority_idx) + i) % NUM_ENTRIES;
			if (request[slot])
			begin
				grant_oh = '0;
				grant_oh[slot] = 1'b1;
				grant_idx = IDX_W'(slot);
			end
		end
	end

	// Rotate past the granted entry
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			priority_idx <= '0;
		else if (update_lru && |grant_oh)
			priority_idx <= IDX_W'((int'(grant_idx) + 1) % NUM_ENTRIES);
	end
endmodule

// ==== design/thread_io_issue.sv ====
/*
 * Per-core thread issue block, stands in for the data stage
 * Holds one I/O command per thread, issues it twice and reports completion
 */
`timescale 1ns/1ps
`include "io_params.svh"

module thread_io_issue
	(input logic clk,
	input logic reset,

	// From outside
	input io_pkg::io_cmd_t cmd,

	// From io_request_queue
	input logic ior_rollback_en,
	input io_pkg::scalar_t ior_read_value,
	input io_pkg::thread_bitmap_t ior_wake_bitmap,

	// To io_request_queue
	output logic dd_io_read_en,
	output logic dd_io_write_en,
	output io_pkg::thread_idx_t dd_io_thread_idx,
	output io_pkg::scalar_t dd_io_addr,
	output io_pkg::scalar_t dd_io_write_value,

	// To outside
	output io_pkg::thread_bitmap_t thread_busy,
	output io_pkg::io_done_t done);

	io_pkg::thread_state_t thread_state[`THREADS_PER_CORE];
	io_pkg::io_op_t cmd_op[`THREADS_PER_CORE];
	io_pkg::scalar_t cmd_addr[`THREADS_PER_CORE];
	io_pkg::scalar_t cmd_value[`THREADS_PER_CORE];
	io_pkg::thread_bitmap_t ready_bitmap;
	io_pkg::thread_bitmap_t issue_oh;
	io_pkg::thread_idx_t issue_idx;
	logic issue_valid;

	// Thread issued last cycle, whose rollback is now visible
	logic issued_last;
	io_pkg::thread_idx_t issued_idx;

	always_comb
	begin
		issue_idx = '0;
		for (int t = 0; t < `THREADS_PER_CORE; t++)
		begin
			ready_bitmap[t] = thread_state[t] == io_pkg::TS_READY;
			thread_busy[t] = thread_state[t] != io_pkg::TS_IDLE;
			if (issue_oh[t])
				issue_idx = io_pkg::thread_idx_t'(t);
		end
	end

	rr_arbiter #(.NUM_ENTRIES(`THREADS_PER_CORE)) issue_arbiter(
		.clk(clk),
		.reset(reset),
		.request(ready_bitmap),
		.update_lru(1'b1),
		.grant_oh(issue_oh));

	// Issue straight from the stored command
	assign issue_valid = |issue_oh;
	assign dd_io_read_en = issue_valid && cmd_op[issue_idx] == io_pkg::IO_READ;
	assign dd_io_write_en = issue_valid && cmd_op[issue_idx] == io_pkg::IO_WRITE;
	assign dd_io_thread_idx = issue_idx;
	assign dd_io_addr = cmd_addr[issue_idx];
	assign dd_io_write_value = cmd_value[issue_idx];

	// Command payload
	always_ff @(posedge clk)
	begin
		if (cmd.valid)
		begin
			cmd_op[cmd.thread_idx] <= cmd.op;
			cmd_addr[cmd.thread_idx] <= cmd.address;
			cmd_value[cmd.thread_idx] <= cmd.value;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int t = 0; t < `THREADS_PER_CORE; t++)
				thread_state[t] <= io_pkg::TS_IDLE;
			issued_last <= 1'b0;
			issued_idx <= '0;
			done <= '0;
		end
		else
		begin
			for (int t = 0; t < `THREADS_PER_CORE; t++)
			begin
				case (thread_state[t])
					io_pkg::TS_IDLE:
						if (cmd.valid && cmd.thread_idx == io_pkg::thread_idx_t'(t))
							thread_state[t] <= io_pkg::TS_READY;

					// Sleep provisionally until the rollback is known
					io_pkg::TS_READY:
						if (issue_oh[t])
							thread_state[t] <= io_pkg::TS_SLEEP;

					io_pkg::TS_SLEEP:
						if (issued_last && issued_idx == io_pkg::thread_idx_t'(t)
							&& !ior_rollback_en)
							thread_state[t] <= io_pkg::TS_FINISH;
						else if (ior_wake_bitmap[t])
							thread_state[t] <= io_pkg::TS_READY;

					default:
						thread_state[t] <= io_pkg::TS_IDLE;
				endcase
			end

			issued_last <= issue_valid;
			issued_idx <= issue_idx;

			// No rollback means the access completed
			done.valid <= issued_last && !ior_rollback_en;
			done.thread_idx <= issued_idx;
			done.value <= ior_read_value;
		end
	end
endmodule

// ==== design/io_request_queue.sv ====
/*
 * Pending uncached requests of one core, one slot per thread
 * First issue records the request and rolls back, second issue collects the result
 */
`timescale 1ns/1ps
`include "io_params.svh"

module io_request_queue
	#(parameter CORE_ID = 0)
	(input logic clk,
	input logic reset,

	// From the issue block
	input logic dd_io_write_en,
	input logic dd_io_read_en,
	input io_pkg::thread_idx_t dd_io_thread_idx,
	input io_pkg::scalar_t dd_io_addr,
	input io_pkg::scalar_t dd_io_write_value,

	// Back to the issue block
	output io_pkg::scalar_t ior_read_value,
	output logic ior_rollback_en,
	output io_pkg::thread_bitmap_t ior_wake_bitmap,

	// To and from the bus controller
	output io_pkg::ioreq_packet_t ior_request,
	input logic ia_ready,
	input io_pkg::iorsp_packet_t ia_response);

	typedef struct packed {
		logic valid;
		logic sent;
		logic is_store;
		io_pkg::scalar_t address;
		io_pkg::scalar_t value;
	} io_slot_t;

	io_slot_t slot[`THREADS_PER_CORE];
	io_pkg::thread_bitmap_t send_request;
	io_pkg::thread_bitmap_t send_grant_oh;
	io_pkg::thread_idx_t send_grant_idx;
	logic issue_en;
	logic rsp_for_core;

	assign issue_en = dd_io_write_en | dd_io_read_en;
	assign rsp_for_core = ia_response.valid
		&& ia_response.core == io_pkg::core_id_t'(CORE_ID);

	// Waiting slots and the chosen slot index
	always_comb
	begin
		send_grant_idx = '0;
		for (int t = 0; t < `THREADS_PER_CORE; t++)
		begin
			send_request[t] = slot[t].valid && !slot[t].sent;
			if (send_grant_oh[t])
				send_grant_idx = io_pkg::thread_idx_t'(t);
		end
	end

	// Rotates only once the bus takes the request
	rr_arbiter #(.NUM_ENTRIES(`THREADS_PER_CORE)) send_arbiter(
		.clk(clk),
		.reset(reset),
		.request(send_request),
		.update_lru(ia_ready),
		.grant_oh(send_grant_oh));

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int t = 0; t < `THREADS_PER_CORE; t++)
				slot[t] <= '0;
		end
		else
		begin
			for (int t = 0; t < `THREADS_PER_CORE; t++)
			begin
				if (issue_en && dd_io_thread_idx == io_pkg::thread_idx_t'(t))
				begin
					if (slot[t].valid)
					begin
						// Result collected so the slot is freed
						slot[t].valid <= 1'b0;
					end
					else
					begin
						// New request
						slot[t].valid <= 1'b1;
						slot[t].sent <= 1'b0;
						slot[t].is_store <= dd_io_write_en;
						slot[t].address <= dd_io_addr;
						slot[t].value <= dd_io_write_value;
					end
				end

				// Response replaces the slot value
				if (rsp_for_core && ia_response.thread_idx == io_pkg::thread_idx_t'(t))
					slot[t].value <= ia_response.read_value;

				if (ia_ready && send_grant_oh[t])
					slot[t].sent <= 1'b1;
			end
		end
	end

	// Wake the responding thread in the response cycle
	always_comb
	begin
		ior_wake_bitmap = '0;
		if (rsp_for_core)
			ior_wake_bitmap[ia_response.thread_idx] = 1'b1;
	end

	// Request level held until accepted
	assign ior_request.valid = |send_grant_oh;
	assign ior_request.is_store = slot[send_grant_idx].is_store;
	assign ior_request.thread_idx = send_grant_idx;
	assign ior_request.address = slot[send_grant_idx].address;
	assign ior_request.value = slot[send_grant_idx].value;

	// Rollback only when the issue opened a new request
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ior_rollback_en <= 1'b0;
			ior_read_value <= '0;
		end
		else
		begin
			ior_rollback_en <= issue_en && !slot[dd_io_thread_idx].valid;
			ior_read_value <= slot[dd_io_thread_idx].value;
		end
	end
endmodule

// ==== design/io_bus_controller.sv ====
/*
 * Shared I/O bus controller with the memory-mapped register bank
 * Accepts one core request per cycle and broadcasts the response to all cores
 */
`timescale 1ns/1ps
`include "io_params.svh"

module io_bus_controller
	(input logic clk,
	input logic reset,

	// Request level from each core's queue
	input io_pkg::ioreq_packet_t core_request[`NUM_CORES],

	// Acceptance level per core, and the response pulse
	output logic [`NUM_CORES - 1:0] ia_ready,
	output io_pkg::iorsp_packet_t ia_response);

	localparam REG_IDX_W = $clog2(`IO_REG_COUNT);

	io_pkg::scalar_t io_regs[`IO_REG_COUNT];
	logic [`NUM_CORES - 1:0] core_valid;
	logic [`NUM_CORES - 1:0] grant_oh;
	io_pkg::core_id_t grant_core;
	io_pkg::ioreq_packet_t granted;
	logic [REG_IDX_W - 1:0] reg_idx;

	always_comb
	begin
		grant_core = '0;
		for (int c = 0; c < `NUM_CORES; c++)
		begin
			core_valid[c] = core_request[c].valid;
			if (grant_oh[c])
				grant_core = io_pkg::core_id_t'(c);
		end
	end

	rr_arbiter #(.NUM_ENTRIES(`NUM_CORES)) core_arbiter(
		.clk(clk),
		.reset(reset),
		.request(core_valid),
		.update_lru(1'b1),
		.grant_oh(grant_oh));

	// Granted core is accepted at the next edge
	assign ia_ready = grant_oh;
	assign granted = core_request[grant_core];

	// Upper address bits ignored
	assign reg_idx = granted.address[REG_IDX_W - 1:0];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int r = 0; r < `IO_REG_COUNT; r++)
				io_regs[r] <= '0;
			ia_response <= '0;
		end
		else
		begin
			ia_response.valid <= |grant_oh;
			ia_response.core <= grant_core;
			ia_response.thread_idx <= granted.thread_idx;

			// A write echoes the written value
			if (granted.is_store)
				ia_response.read_value <= granted.value;
			else
				ia_response.read_value <= io_regs[reg_idx];

			if (|grant_oh && granted.is_store)
				io_regs[reg_idx] <= granted.value;
		end
	end
endmodule

// ==== design/io_subsystem_top.sv ====
/*
 * Two cores of issue block and request queue on one shared I/O bus
 * The testbench drives commands per core and watches busy and done
 */
`timescale 1ns/1ps
`include "io_params.svh"

module io_subsystem_top
	(input logic clk,
	input logic reset,
	input io_pkg::io_cmd_t cmd[`NUM_CORES],
	output io_pkg::thread_bitmap_t thread_busy[`NUM_CORES],
	output io_pkg::io_done_t done[`NUM_CORES]);

	io_pkg::ioreq_packet_t core_request[`NUM_CORES];
	logic [`NUM_CORES - 1:0] ia_ready;
	io_pkg::iorsp_packet_t ia_response;

	generate
		for (genvar c = 0; c < `NUM_CORES; c++)
		begin : core_gen
			// Issue block to queue
			logic dd_io_read_en;
			logic dd_io_write_en;
			io_pkg::thread_idx_t dd_io_thread_idx;
			io_pkg::scalar_t dd_io_addr;
			io_pkg::scalar_t dd_io_write_value;

			// Queue back to issue block
			logic ior_rollback_en;
			io_pkg::scalar_t ior_read_value;
			io_pkg::thread_bitmap_t ior_wake_bitmap;

			thread_io_issue issue(
				.clk(clk),
				.reset(reset),
				.cmd(cmd[c]),
				.ior_rollback_en(ior_rollback_en),
				.ior_read_value(ior_read_value),
				.ior_wake_bitmap(ior_wake_bitmap),
				.dd_io_read_en(dd_io_read_en),
				.dd_io_write_en(dd_io_write_en),
				.dd_io_thread_idx(dd_io_thread_idx),
				.dd_io_addr(dd_io_addr),
				.dd_io_write_value(dd_io_write_value),
				.thread_busy(thread_busy[c]),
				.done(done[c]));

			io_request_queue #(.CORE_ID(c)) ioq(
				.clk(clk),
				.reset(reset),
				.dd_io_write_en(dd_io_write_en),
				.dd_io_read_en(dd_io_read_en),
				.dd_io_thread_idx(dd_io_thread_idx),
				.dd_io_addr(dd_io_addr),
				.dd_io_write_value(dd_io_write_value),
				.ior_read_value(ior_read_value),
				.ior_rollback_en(ior_rollback_en),
				.ior_wake_bitmap(ior_wake_bitmap),
				.ior_request(core_request[c]),
				.ia_ready(ia_ready[c]),
				.ia_response(ia_response));
		end
	endgenerate

	io_bus_controller bus(
		.clk(clk),
		.reset(reset),
		.core_request(core_request),
		.ia_ready(ia_ready),
		.ia_response(ia_response));
endmodule

// ==== tests/io_subsystem_sva.sv ====
/*
 * Concurrent checks on one core's request queue, bound to every io_request_queue
 * The failure count is read by the testbench at the end of the run
 */
`timescale 1ns/1ps
`include "io_params.svh"

module io_request_queue_sva
	#(parameter CORE_ID = 0)
	(input logic clk,
	input logic reset,
	input logic dd_io_write_en,
	input logic dd_io_read_en,
	input io_pkg::thread_idx_t dd_io_thread_idx,
	input logic ior_rollback_en,
	input logic ia_ready,
	input io_pkg::ioreq_packet_t ior_request,
	input io_pkg::iorsp_packet_t ia_response,
	input io_pkg::thread_bitmap_t slot_valid,
	input io_pkg::thread_bitmap_t slot_sent);

	int unsigned failures;
	logic rsp_here;

	initial failures = 0;

	// Response addressed to this core
	assign rsp_here = ia_response.valid
		&& ia_response.core == io_pkg::core_id_t'(CORE_ID);

	// Only a slot that is on the bus may get a response
	response_needs_sent_slot: assert property (@(posedge clk) disable iff (reset)
		rsp_here |-> slot_valid[ia_response.thread_idx] && slot_sent[ia_response.thread_idx])
	else
	begin
		$error("Response for a thread whose slot is not waiting on the bus");
		failures++;
	end

	// Request level stays up until the bus takes it
	request_held_until_accepted: assert property (@(posedge clk) disable iff (reset)
		ior_request.valid && !ia_ready |=> ior_request.valid)
	else
	begin
		$error("Request valid dropped before the bus accepted it");
		failures++;
	end

	// Rollback answers an issue strobe and leaves that thread's new request unsent
	rollback_follows_issue: assert property (@(posedge clk) disable iff (reset)
		ior_rollback_en |-> $past(dd_io_read_en || dd_io_write_en)
			&& slot_valid[$past(dd_io_thread_idx)]
			&& !slot_sent[$past(dd_io_thread_idx)])
	else
	begin
		$error("Rollback raised without a new request opened by the issue the cycle before");
		failures++;
	end
endmodule

// ==== tests/io_subsystem_tb.sv ====
/*
 * Testbench for the two-core uncached I/O path
 * Sends commands per core, predicts results from a register model and checks every done
 */
`timescale 1ns/1ps
`include "io_params.svh"

module io_subsystem_tb;

	localparam REG_W = $clog2(`IO_REG_COUNT);
	localparam THR_W = $clog2(`THREADS_PER_CORE);
	localparam ALL_THREADS = `NUM_CORES * `THREADS_PER_CORE;
	localparam WAIT_LIMIT = 300;

	logic clk;
	logic reset;
	io_pkg::io_cmd_t cmd[`NUM_CORES];
	io_pkg::thread_bitmap_t thread_busy[`NUM_CORES];
	io_pkg::io_done_t done[`NUM_CORES];

	// Register model, updated in command order
	io_pkg::scalar_t ref_regs[`IO_REG_COUNT];

	// Outstanding commands and their predicted results
	logic pending[`NUM_CORES][`THREADS_PER_CORE];
	logic [REG_W - 1:0] pending_reg[`NUM_CORES][`THREADS_PER_CORE];
	io_pkg::scalar_t expected[`NUM_CORES][`THREADS_PER_CORE];

	logic [31:0] lfsr;
	int checks;
	int errors;
	int test_base;
	int completed;
	int issued;

	io_subsystem_top dut(
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.thread_busy(thread_busy),
		.done(done));

	bind io_request_queue io_request_queue_sva #(.CORE_ID(CORE_ID)) queue_sva(
		.clk(clk),
		.reset(reset),
		.dd_io_write_en(dd_io_write_en),
		.dd_io_read_en(dd_io_read_en),
		.dd_io_thread_idx(dd_io_thread_idx),
		.ior_rollback_en(ior_rollback_en),
		.ia_ready(ia_ready),
		.ior_request(ior_request),
		.ia_response(ia_response),
		.slot_valid({slot[3].valid, slot[2].valid, slot[1].valid, slot[0].valid}),
		.slot_sent({slot[3].sent, slot[2].sent, slot[1].sent, slot[0].sent}));

	always #4 clk = !clk;

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hD0000001 : lfsr >> 1;
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	// Random upper bits, which the bus ignores
	function automatic io_pkg::scalar_t address_of(input logic [REG_W - 1:0] r);
		io_pkg::scalar_t a;
		a = take_bits(`IO_DATA_WIDTH);
		a[REG_W - 1:0] = r;
		return a;
	endfunction

	function automatic logic any_pending();
		logic found;
		found = 1'b0;
		for (int c = 0; c < `NUM_CORES; c++)
			for (int t = 0; t < `THREADS_PER_CORE; t++)
				found |= pending[c][t];
		return found;
	endfunction

	// Keeps conflicting accesses sequential
	function automatic logic reg_in_flight(input logic [REG_W - 1:0] r);
		logic found;
		found = 1'b0;
		for (int c = 0; c < `NUM_CORES; c++)
			for (int t = 0; t < `THREADS_PER_CORE; t++)
				found |= pending[c][t] && pending_reg[c][t] == r;
		return found;
	endfunction

	task automatic expect_true(input logic ok, input string what);
		checks++;
		assert (ok)
		else
		begin
			$display("Check failed at %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic compare_value(input io_pkg::scalar_t actual, input io_pkg::scalar_t want,
		input string what);
		checks++;
		assert (actual == want)
		else
		begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, want);
			errors++;
		end
	endtask

	// Commands are one-cycle strobes
	task automatic next_cycle();
		@(posedge clk);
		for (int c = 0; c < `NUM_CORES; c++)
			cmd[c] <= '0;
	endtask

	task automatic send(input int c, input int t, input io_pkg::io_op_t op,
		input io_pkg::scalar_t address, input io_pkg::scalar_t value);
		io_pkg::io_cmd_t next;
		logic [REG_W - 1:0] r;
		r = address[REG_W - 1:0];
		next.valid = 1'b1;
		next.thread_idx = io_pkg::thread_idx_t'(t);
		next.op = op;
		next.address = address;
		next.value = value;
		cmd[c] <= next;

		// A write completes with its own data
		if (op == io_pkg::IO_WRITE)
			ref_regs[r] = value;
		expected[c][t] = ref_regs[r];
		pending[c][t] = 1'b1;
		pending_reg[c][t] = r;
		issued++;
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (any_pending() && cycles < WAIT_LIMIT)
		begin
			next_cycle();
			cycles++;
		end
		for (int c = 0; c < `NUM_CORES; c++)
			for (int t = 0; t < `THREADS_PER_CORE; t++)
				if (pending[c][t])
				begin
					$display("Timeout: core %0d thread %0d did not complete in %0d cycles",
						c, t, WAIT_LIMIT);
					errors++;
					pending[c][t] = 1'b0;
				end
	endtask

	task automatic finish_test(input string name);
		$display("Test %s finished with %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	// Every done must match an outstanding command and its predicted value
	always @(posedge clk)
	begin
		int t;
		if (!reset)
		begin
			for (int c = 0; c < `NUM_CORES; c++)
			begin
				if (done[c].valid)
				begin
					t = int'(done[c].thread_idx);
					expect_true(pending[c][t],
						$sformatf("core %0d thread %0d completed with nothing outstanding", c, t));
					compare_value(done[c].value, expected[c][t],
						$sformatf("core %0d thread %0d done value", c, t));
					pending[c][t] = 1'b0;
					completed++;
				end
			end
		end
	end

	initial
	begin
		logic [REG_W - 1:0] base;
		logic [REG_W - 1:0] r;
		io_pkg::io_op_t op;
		io_pkg::scalar_t value;
		int t;
		int done_base;
		int issue_base;
		int sva_failures;

		clk = 1'b0;
		reset = 1'b1;
		lfsr = 32'd93756;
		checks = 0;
		errors = 0;
		test_base = 0;
		completed = 0;
		issued = 0;
		for (int c = 0; c < `NUM_CORES; c++)
		begin
			cmd[c] = '0;
			for (int k = 0; k < `THREADS_PER_CORE; k++)
				pending[c][k] = 1'b0;
		end
		for (int k = 0; k < `IO_REG_COUNT; k++)
			ref_regs[k] = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// Quiet after reset, then every register reads zero
		repeat (20)
		begin
			next_cycle();
			for (int c = 0; c < `NUM_CORES; c++)
				expect_true(thread_busy[c] == '0 && !done[c].valid,
					$sformatf("core %0d busy or done while idle after reset", c));
		end
		for (int k = 0; k < `IO_REG_COUNT; k++)
		begin
			next_cycle();
			send(k % `NUM_CORES, (k / `NUM_CORES) % `THREADS_PER_CORE, io_pkg::IO_READ,
				io_pkg::scalar_t'(k), '0);
			if (k % ALL_THREADS == ALL_THREADS - 1)
				wait_idle();
		end
		finish_test("reset state");

		// Write from core 0 thread 1, read back from core 1
		base = REG_W'(take_bits(REG_W));
		value = take_bits(`IO_DATA_WIDTH);
		next_cycle();
		send(0, 1, io_pkg::IO_WRITE, address_of(base), value);
		wait_idle();
		next_cycle();
		send(1, 2, io_pkg::IO_READ, address_of(base), '0);
		wait_idle();
		finish_test("write then read");

		// All threads at once on registers a stride of 5 apart
		base = REG_W'(take_bits(REG_W));
		done_base = completed;
		for (int k = 0; k < ALL_THREADS; k++)
		begin
			r = base + REG_W'(5 * k);
			op = io_pkg::io_op_t'(take_bits(1));
			value = take_bits(`IO_DATA_WIDTH);
			next_cycle();
			send(k % `NUM_CORES, k / `NUM_CORES, op, address_of(r), value);
		end
		wait_idle();
		next_cycle();
		expect_true(completed - done_base == ALL_THREADS, "not one done per thread");
		for (int c = 0; c < `NUM_CORES; c++)
			expect_true(thread_busy[c] == '0,
				$sformatf("core %0d busy bits still set after done", c));
		finish_test("full concurrency");

		// Same thread number on both cores, different registers
		base = REG_W'(take_bits(REG_W));
		value = take_bits(`IO_DATA_WIDTH);
		next_cycle();
		send(0, 0, io_pkg::IO_WRITE, address_of(base), value);
		wait_idle();
		next_cycle();
		send(1, 0, io_pkg::IO_WRITE, address_of(base + 1'b1), ~value);
		wait_idle();
		next_cycle();
		send(0, 3, io_pkg::IO_READ, address_of(base), '0);
		send(1, 3, io_pkg::IO_READ, address_of(base + 1'b1), '0);
		wait_idle();
		finish_test("core routing");

		// Random streams to any idle thread
		done_base = completed;
		issue_base = issued;
		repeat (400)
		begin
			next_cycle();
			for (int c = 0; c < `NUM_CORES; c++)
			begin
				if (take_bits(1) == 1)
				begin
					t = int'(take_bits(THR_W));
					r = REG_W'(take_bits(REG_W));
					op = io_pkg::io_op_t'(take_bits(1));
					value = take_bits(`IO_DATA_WIDTH);
					if (!thread_busy[c][t] && !pending[c][t] && !reg_in_flight(r))
						send(c, t, op, address_of(r), value);
				end
			end
		end
		wait_idle();
		expect_true(completed - done_base == issued - issue_base,
			"completions do not match the commands sent");
		sva_failures = dut.core_gen[0].ioq.queue_sva.failures
			+ dut.core_gen[1].ioq.queue_sva.failures;
		expect_true(sva_failures == 0,
			$sformatf("%0d request queue assertion failures", sva_failures));
		finish_test("contention and reuse");

		$display("Checks: %0d, errors: %0d, completions: %0d", checks, errors, completed);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end
endmodule

// ==== vlog.f ====
+incdir+design
design/io_pkg.sv
design/rr_arbiter.sv
design/thread_io_issue.sv
design/io_request_queue.sv
design/io_bus_controller.sv
design/io_subsystem_top.sv
tests/io_subsystem_sva.sv
tests/io_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: io_subsystem

sources:
  - include_dirs:
      - design
    files:
      - design/io_pkg.sv
      - design/rr_arbiter.sv
      - design/thread_io_issue.sv
      - design/io_request_queue.sv
      - design/io_bus_controller.sv
      - design/io_subsystem_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/io_subsystem_sva.sv
      - tests/io_subsystem_tb.sv
